/* hdl/ethFramePkg.sv */
package ethFramePkg;

  // one received byte off the stream.
  typedef logic [7:0] byteT;

  typedef logic [47:0] macAddrT;  // station address.
  typedef logic [5:0]  hashIdxT;  // index into the 64-bit hash table.

  // one half of the hash table.
  typedef logic [31:0] hashTableT;

  localparam byteT preambleByte = 8'h55;
  localparam byteT sfdByte      = 8'hD5;

  // destination address length in bytes.
  localparam int addrBytes = 6;

  // ethernet crc-32 generator.
  localparam logic [31:0] crcPoly = 32'h04C11DB7;

endpackage

/* hdl/ethRxCtrlPkg.sv */
package ethRxCtrlPkg;

  typedef enum logic [2:0]
  {
    Idle,
    Preamble,
    Data,
    Drop,     // rejected frame, wait for end.
    Status    // status handshake with the consumer.
  } rxStateT;

  typedef logic [15:0] byteCntT;  // frame length in bytes.

endpackage

/* hdl/ethRxStateM.sv */
module ethRxStateM
(
  input  logic                  MRxClk,
  input  logic                  Reset,
  input  logic                  RxDv,
  input  ethFramePkg::byteT     RxData,
  input  logic                  RxAbort,
  input  logic                  AddressMiss,
  input  ethRxCtrlPkg::byteCntT ByteCnt,
  input  logic                  StatusAck,
  output logic                  CntClear,
  output logic                  CntEn,
  output logic                  RxCheckEn,
  output logic                  RxEndFrm,
  output logic                  StatusReq,
  output logic                  StatusMiss,
  output logic                  StatusAbort,
  output ethRxCtrlPkg::byteCntT StatusLen
);
  import ethFramePkg::*;
  import ethRxCtrlPkg::*;

  rxStateT State;
  rxStateT NextState;
  logic    InFrame;

  assign InFrame   = (State == Data) || (State == Drop);
  assign CntClear  = (State == Idle) || (State == Preamble);
  assign CntEn     = InFrame && RxDv;
  assign RxCheckEn = (State == Data) && RxDv;  // address checks only on live bytes.
  assign RxEndFrm  = InFrame && !RxDv;

  always_comb
  begin
    NextState = State;
    case (State)
      Idle:
        if (RxDv && (RxData == preambleByte))
          NextState = Preamble;
      Preamble:
        if (RxDv && (RxData == sfdByte))
          NextState = Data;
        else if (!RxDv || (RxData != preambleByte))
          NextState = Idle;  // broken preamble.
      Data:
        if (!RxDv)
          NextState = Status;
        else if (RxAbort)
          NextState = Drop;
      Drop:
        if (!RxDv)
          NextState = Status;
      // leave only after ack has dropped and the line is quiet,
      // so a frame arriving during the handshake is skipped whole.
      Status:
        if (!StatusReq && !StatusAck && !RxDv)
          NextState = Idle;
      default:
        NextState = Idle;
    endcase
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      State       <= Idle;
      StatusReq   <= 1'b0;
      StatusMiss  <= 1'b0;
      StatusAbort <= 1'b0;
      StatusLen   <= '0;
    end
    else
    begin
      State <= NextState;
      if (RxEndFrm)
      begin
        StatusReq   <= 1'b1;
        StatusMiss  <= AddressMiss;
        StatusAbort <= (State == Drop) || RxAbort;  // abort may land on the last byte.
        StatusLen   <= ByteCnt;
      end
      else if (StatusAck)
        StatusReq <= 1'b0;
    end
  end

endmodule

/* hdl/ethRxCounter.sv */
module ethRxCounter
(
  input  logic                  MRxClk,
  input  logic                  Reset,
  input  logic                  CntClear,
  input  logic                  CntEn,
  output ethRxCtrlPkg::byteCntT ByteCnt,
  output logic                  AddrByteEq0,
  output logic                  AddrByteEq1,
  output logic                  AddrByteEq2,
  output logic                  AddrByteEq3,
  output logic                  AddrByteEq4,
  output logic                  AddrByteEq5,
  output logic                  AddrByteEq6
);
  import ethFramePkg::*;
  import ethRxCtrlPkg::*;

  logic [addrBytes:0] PosHit;  // one bit per address position.

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
      ByteCnt <= '0;
    else if (CntClear)
      ByteCnt <= '0;
    else if (CntEn && (ByteCnt != '1))
      ByteCnt <= ByteCnt + 1'b1;  // saturates on long frames.
  end

  always_comb
  begin
    for (int i = 0; i <= addrBytes; i++)
      PosHit[i] = (ByteCnt == byteCntT'(i));
  end

  assign AddrByteEq0 = PosHit[0];
  assign AddrByteEq1 = PosHit[1];
  assign AddrByteEq2 = PosHit[2];
  assign AddrByteEq3 = PosHit[3];
  assign AddrByteEq4 = PosHit[4];
  assign AddrByteEq5 = PosHit[5];
  assign AddrByteEq6 = PosHit[6];  // first byte after the destination.

endmodule

/* hdl/ethRxCrcHash.sv */
module ethRxCrcHash
(
  input  logic                 MRxClk,
  input  logic                 Reset,
  input  ethFramePkg::byteT    RxData,
  input  logic                 CntClear,
  input  logic                 AddrByteEq0,
  input  logic                 AddrByteEq1,
  input  logic                 AddrByteEq2,
  input  logic                 AddrByteEq3,
  input  logic                 AddrByteEq4,
  input  logic                 AddrByteEq5,
  input  logic                 RxEndFrm,
  output ethFramePkg::hashIdxT CrcHash,
  output logic                 CrcHashGood
);
  import ethFramePkg::*;

  logic [31:0] Crc;
  logic        AddrField;

  // one byte of crc-32, bits enter lsb first as on the wire.
  function automatic logic [31:0] crcNext(input logic [31:0] crcIn, input byteT data);
    logic [31:0] c;
    logic        fb;
    c = crcIn;
    for (int i = 0; i < $bits(byteT); i++)
    begin
      fb = c[31] ^ data[i];
      c  = {c[30:0], 1'b0};
      if (fb)
        c = c ^ crcPoly;
    end
    return c;
  endfunction

  assign AddrField = AddrByteEq0 | AddrByteEq1 | AddrByteEq2 |
                     AddrByteEq3 | AddrByteEq4 | AddrByteEq5;

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      Crc         <= '1;
      CrcHashGood <= 1'b0;
    end
    else if (CntClear)
    begin
      Crc         <= '1;   // seed for the next frame.
      CrcHashGood <= 1'b0;
    end
    else
    begin
      if (AddrField)
        Crc <= crcNext(Crc, RxData);
      if (RxEndFrm)
        CrcHashGood <= 1'b0;
      else if (AddrByteEq5)
        CrcHashGood <= 1'b1;  // last destination byte absorbed.
    end
  end

  assign CrcHash = Crc[31:26];

endmodule

/* hdl/ethRxAddrCheck.sv */
module ethRxAddrCheck
(
  input  logic                   MRxClk,
  input  logic                   Reset,
  input  ethFramePkg::byteT      RxData,
  input  logic                   RxCheckEn,
  input  logic                   RxEndFrm,
  input  logic                   AddrByteEq0,
  input  logic                   AddrByteEq1,
  input  logic                   AddrByteEq2,
  input  logic                   AddrByteEq3,
  input  logic                   AddrByteEq4,
  input  logic                   AddrByteEq5,
  input  logic                   AddrByteEq6,
  input  ethFramePkg::hashIdxT   CrcHash,
  input  logic                   CrcHashGood,
  input  ethFramePkg::macAddrT   Mac,
  input  ethFramePkg::hashTableT Hash0,
  input  ethFramePkg::hashTableT Hash1,
  input  logic                   RBro,
  input  logic                   RPro,
  output logic                   RxAbort,
  output logic                   AddressMiss
);
  import ethFramePkg::*;

  byteT      MacByte;
  logic      AddrField;
  logic      ByteMatch;
  logic      UnicastOk;
  logic      Broadcast;
  logic      Multicast;
  hashTableT HashHalf;
  logic      HashBit;
  logic      AddrHit;
  logic      AddrDecide;

  // station address byte expected at this position, msb byte first.
  always_comb
  begin
    if (AddrByteEq0)
      MacByte = Mac[47:40];
    else if (AddrByteEq1)
      MacByte = Mac[39:32];
    else if (AddrByteEq2)
      MacByte = Mac[31:24];
    else if (AddrByteEq3)
      MacByte = Mac[23:16];
    else if (AddrByteEq4)
      MacByte = Mac[15:8];
    else
      MacByte = Mac[7:0];
  end

  assign AddrField  = AddrByteEq1 | AddrByteEq2 | AddrByteEq3 | AddrByteEq4 | AddrByteEq5;
  assign ByteMatch  = (RxData == MacByte);
  assign HashHalf   = CrcHash[5] ? Hash1 : Hash0;
  assign HashBit    = HashHalf[CrcHash[4:0]];
  // broadcast has the group bit set too, keep it out of the hash lookup.
  assign AddrHit    = UnicastOk | (Broadcast & ~RBro) |
                      (Multicast & ~Broadcast & CrcHashGood & HashBit);
  assign AddrDecide = RxCheckEn & AddrByteEq6;

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      UnicastOk <= 1'b0;
      Broadcast <= 1'b0;
      Multicast <= 1'b0;
    end
    else if (RxCheckEn && AddrByteEq0)
    begin
      UnicastOk <= ByteMatch;
      Broadcast <= &RxData;
      Multicast <= RxData[0];  // group bit.
    end
    else if (RxCheckEn && AddrField)
    begin
      UnicastOk <= UnicastOk & ByteMatch;
      Broadcast <= Broadcast & (&RxData);
    end
  end

  always_ff @(posedge MRxClk or posedge Reset)
  begin
    if (Reset)
    begin
      RxAbort     <= 1'b0;
      AddressMiss <= 1'b1;
    end
    else
    begin
      RxAbort <= AddrDecide & ~AddrHit & ~RPro;  // single cycle pulse.
      if (AddrDecide)
        AddressMiss <= ~AddrHit;
      else if (RxEndFrm || (RxCheckEn && AddrByteEq0))
        AddressMiss <= 1'b1;  // miss until the decision says otherwise.
    end
  end

endmodule

/* hdl/ethRxFilter.sv */
module ethRxFilter
(
  input  logic                   MRxClk,
  input  logic                   Reset,
  input  logic                   RxDv,
  input  ethFramePkg::byteT      RxData,
  input  ethFramePkg::macAddrT   Mac,
  input  ethFramePkg::hashTableT Hash0,
  input  ethFramePkg::hashTableT Hash1,
  input  logic                   RBro,
  input  logic                   RPro,
  output logic                   StatusReq,
  output logic                   StatusMiss,
  output logic                   StatusAbort,
  output ethRxCtrlPkg::byteCntT  StatusLen,
  input  logic                   StatusAck
);
  import ethFramePkg::*;
  import ethRxCtrlPkg::*;

  logic    CntClear;
  logic    CntEn;
  logic    RxCheckEn;
  logic    RxEndFrm;
  logic    RxAbort;
  logic    AddressMiss;
  byteCntT ByteCnt;
  logic    AddrByteEq0;
  logic    AddrByteEq1;
  logic    AddrByteEq2;
  logic    AddrByteEq3;
  logic    AddrByteEq4;
  logic    AddrByteEq5;
  logic    AddrByteEq6;
  hashIdxT CrcHash;
  logic    CrcHashGood;

  // framing and status handshake.
  ethRxStateM stateM (.*);

  // byte position within the frame.
  ethRxCounter counter (.*);

  ethRxCrcHash crcHash (.*);

  // address rules, drives abort and miss back to the fsm.
  ethRxAddrCheck addrCheck (.*);

endmodule

/* tests/ethRxFilter_sva.sv */
module ethRxFilterSva
(
  input logic                  MRxClk,
  input logic                  Reset,
  input logic                  RPro,
  input logic                  RxAbort,
  input logic                  CntEn,
  input logic                  RxEndFrm,
  input logic                  StatusReq,
  input logic                  StatusAck,
  input logic                  StatusMiss,
  input logic                  StatusAbort,
  input ethRxCtrlPkg::byteCntT StatusLen
);

  // abort is a single cycle pulse.
  abortPulse: assert property (@(posedge MRxClk) disable iff (Reset)
    RxAbort |=> !RxAbort)
    else $error("RxAbort lasted more than one cycle");

  noAbortPro: assert property (@(posedge MRxClk) disable iff (Reset)
    RPro |-> !RxAbort)
    else $error("RxAbort raised in promiscuous mode");

  // req waits for the consumer.
  reqHeld: assert property (@(posedge MRxClk) disable iff (Reset)
    StatusReq && !StatusAck |=> StatusReq)
    else $error("StatusReq dropped before StatusAck");

  // status word frozen until ack falls.
  statusHeld: assert property (@(posedge MRxClk) disable iff (Reset)
    $past(StatusReq || StatusAck) && (StatusReq || StatusAck)
      |-> $stable({StatusMiss, StatusAbort, StatusLen}))
    else $error("status values changed during the handshake");

  resetQuiet: assert property (@(posedge MRxClk)
    Reset |-> !StatusReq && !RxAbort && !CntEn && !RxEndFrm)
    else $error("outputs active during reset");

endmodule

/* tests/ethRxFilterTb.sv */
module ethRxFilterTb;
  import ethFramePkg::*;
  import ethRxCtrlPkg::*;

  localparam int waitLimit = 200;

  logic      MRxClk;
  logic      Reset;
  logic      RxDv;
  byteT      RxData;
  macAddrT   Mac;
  hashTableT Hash0;
  hashTableT Hash1;
  logic      RBro;
  logic      RPro;
  logic      StatusReq;
  logic      StatusMiss;
  logic      StatusAbort;
  byteCntT   StatusLen;
  logic      StatusAck;

  int seed;
  int testNum;
  int failedTests;
  int errTotal;
  int testErrs;

  ethRxFilter uut (.*);

  bind ethRxFilter ethRxFilterSva sva (.*);

  always #2 MRxClk = ~MRxClk;

  // reflected crc-32 over the destination, first byte first, lsb first.
  function automatic hashIdxT modelHash(input macAddrT dest);
    logic [31:0] crc;
    logic        inBit;
    crc = 32'hFFFF_FFFF;
    for (int b = 0; b < addrBytes; b++)
      for (int k = 0; k < 8; k++)
      begin
        inBit = dest[40 - 8*b + k];
        crc   = {crc[30:0], 1'b0} ^ ((crc[31] ^ inBit) ? 32'h04C1_1DB7 : 32'h0);
      end
    return crc[31:26];
  endfunction

  function automatic logic expectMiss(input macAddrT dest);
    logic [63:0] hashTable;
    hashTable = {Hash1, Hash0};
    if (dest == Mac)
      return 1'b0;
    if (dest == '1)
      return RBro;  // broadcast refused only by RBro.
    if (dest[40])
      return !hashTable[modelHash(dest)];
    return 1'b1;
  endfunction

  function automatic int randLen();
    int r;
    r = $random(seed);
    return 7 + (r & 15);  // always reaches the decision byte.
  endfunction

  task automatic sendFrame(input macAddrT dest, input int dataLen);
    int r;
    for (int i = 0; i < 8; i++)
    begin
      @(posedge MRxClk);
      RxDv   <= 1'b1;
      RxData <= (i == 7) ? sfdByte : preambleByte;
    end
    for (int i = 0; i < dataLen; i++)
    begin
      @(posedge MRxClk);
      r = $random(seed);
      RxData <= (i < addrBytes) ? dest[47 - 8*i -: 8] : r[7:0];
    end
    @(posedge MRxClk);
    RxDv   <= 1'b0;
    RxData <= 8'h00;
  endtask

  task automatic awaitReq(input logic level, input int limit, output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && (n < limit))
    begin
      @(posedge MRxClk);
      n++;
      seen = (StatusReq == level);
    end
  endtask

  task automatic requireReq(input logic level, input string what);
    bit seen;
    awaitReq(level, waitLimit, seen);
    if (!seen)
    begin
      $display("Timeout: %s", what);
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  task automatic checkStatus(input logic expMiss, input logic expAbort, input byteCntT expLen);
    assert (StatusMiss == expMiss)
    else
    begin
      $display("Error: StatusMiss = %h, expected %h", StatusMiss, expMiss);
      testErrs++;
    end
    assert (StatusAbort == expAbort)
    else
    begin
      $display("Error: StatusAbort = %h, expected %h", StatusAbort, expAbort);
      testErrs++;
    end
    assert (StatusLen == expLen)
    else
    begin
      $display("Error: StatusLen = %h, expected %h", StatusLen, expLen);
      testErrs++;
    end
  endtask

  // consumer side of the four-phase handshake.
  task automatic respond();
    int r;
    r = $random(seed);
    repeat (r & 15) @(posedge MRxClk);
    StatusAck <= 1'b1;
    requireReq(1'b0, "StatusReq stayed high after StatusAck");
    StatusAck <= 1'b0;
    repeat (2) @(posedge MRxClk);
  endtask

  task automatic runFrame(input macAddrT dest, input int len);
    logic expMiss;
    expMiss = (len < 7) ? 1'b1 : expectMiss(dest);
    sendFrame(dest, len);
    requireReq(1'b1, "StatusReq never rose after a frame");
    checkStatus(expMiss, expMiss & ~RPro & (len >= 7), byteCntT'(len));
    respond();
  endtask

  task automatic applyMode(input logic bro, input logic pro);
    @(posedge MRxClk);
    RBro <= bro;
    RPro <= pro;
    @(posedge MRxClk);
  endtask

  task automatic endTest(input string name);
    testNum++;
    errTotal += testErrs;
    if (testErrs != 0)
      failedTests++;
    $display("test %0d %s: %s", testNum, name, (testErrs == 0) ? "ok" : "failed");
    testErrs = 0;
  endtask

  initial
  begin
    int      r;
    int      r2;
    macAddrT dest;
    hashIdxT h;
    bit      seen;
    logic [3:0]  covered;
    logic [63:0] hashTable;
    seed        = 32'h6e27_031d;
    testNum     = 0;
    failedTests = 0;
    errTotal    = 0;
    testErrs    = 0;
    MRxClk      = 1'b0;
    Reset       = 1'b1;
    RxDv        = 1'b0;
    RxData      = 8'h00;
    Mac         = 48'h02_1A_2B_3C_4D_5E;
    Hash0       = 32'h8421_C3A5;
    Hash1       = 32'h5A3C_1248;
    RBro        = 1'b0;
    RPro        = 1'b0;
    StatusAck   = 1'b0;
    repeat (8) @(posedge MRxClk);
    Reset <= 1'b0;
    repeat (2) @(posedge MRxClk);

    runFrame(Mac, randLen());
    for (int pos = 0; pos < addrBytes; pos++)
      runFrame(Mac ^ (48'h02 << (40 - 8*pos)), randLen());  // one wrong byte.
    endTest("unicast");

    runFrame('1, randLen());
    applyMode(1'b1, 1'b0);
    runFrame('1, randLen());
    applyMode(1'b0, 1'b0);
    endTest("broadcast");

    // hunt for set and clear bits in both table halves.
    covered   = 4'h0;
    hashTable = {Hash1, Hash0};
    for (int t = 0; (t < 64) && (covered != 4'hF); t++)
    begin
      r  = $random(seed);
      r2 = $random(seed);
      dest     = {r[15:0], r2};
      dest[40] = 1'b1;
      h        = modelHash(dest);
      if ((dest != '1) && !covered[{h[5], hashTable[h]}])
      begin
        covered[{h[5], hashTable[h]}] = 1'b1;
        runFrame(dest, randLen());
      end
    end
    assert (covered == 4'hF)
    else
    begin
      $display("multicast addresses did not reach every hash table case");
      testErrs++;
    end
    endTest("multicast");

    applyMode(1'b0, 1'b1);
    runFrame(Mac ^ 48'h00_00_00_00_01_00, randLen());
    applyMode(1'b0, 1'b0);
    endTest("promiscuous");

    runFrame(Mac, 5);
    endTest("short frame");

    // second frame starts while the handshake is open and outlasts it.
    r = randLen();
    sendFrame(Mac, r);
    requireReq(1'b1, "StatusReq never rose after a frame");
    checkStatus(1'b0, 1'b0, byteCntT'(r));
    fork
      sendFrame(48'h02_00_00_00_00_01, randLen());
      begin
        StatusAck <= 1'b1;  // handshake closes inside the preamble.
        requireReq(1'b0, "StatusReq stayed high after StatusAck");
        StatusAck <= 1'b0;
      end
    join
    awaitReq(1'b1, 20, seen);
    assert (!seen)
    else
    begin
      $display("a frame sent during the handshake produced a status");
      testErrs++;
    end
    runFrame(Mac, randLen());
    endTest("back-pressure");

    $display("%0d tests, %0d failed, %0d errors", testNum, failedTests, errTotal);
    if (failedTests == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* ethRxFilter.f */
hdl/ethFramePkg.sv
hdl/ethRxCtrlPkg.sv
hdl/ethRxStateM.sv
hdl/ethRxCounter.sv
hdl/ethRxCrcHash.sv
hdl/ethRxAddrCheck.sv
hdl/ethRxFilter.sv
tests/ethRxFilter_sva.sv
tests/ethRxFilterTb.sv

/* Makefile */
# Verilator build and run of the receive address filter testbench.

VERILATOR ?= verilator
TOP       ?= ethRxFilterTb
FILELIST  ?= ethRxFilter.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASSMSG   ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
